//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_routing_lookup
FILELIST  := routing_lookup_top.f

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/routing_consts.svh
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -q '^Simulation PASSED$$'

clean:
	rm -rf obj_dir

//--- hw/lookup_pipeline.sv
`timescale 1ns/1ns
`include "routing_consts.svh"

module lookup_pipeline (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              system_ready,
    input  logic [$clog2(`ROUTE_MAX_HOSTS):0] cfg_host_count,
    input  routing_pkg::switch_id_t           cfg_max_sw_id,
    input  logic                              req_valid,
    input  routing_pkg::switch_id_t           req_src_sw,
    input  routing_pkg::host_idx_t            req_dst_host,
    input  routing_pkg::host_entry_t          host_rdata,
    input  routing_pkg::path_entry_t          path_rdata [`ROUTE_MAX_SWITCHES],
    output routing_pkg::host_idx_t            host_raddr,
    output routing_pkg::switch_id_t           path_raddr,
    output logic                              resp_valid,
    output logic                              resp_path_valid,
    output routing_pkg::ip_addr_t             resp_host_ip,
    output routing_pkg::port_t                resp_out_port,
    output routing_pkg::ip_addr_t             resp_next_hop_ip
);

    import routing_pkg::*;

    logic        req_take;
    logic        req_miss;
    logic        s1_vld;
    switch_id_t  s1_src;
    logic        s1_miss;
    logic        s2_vld;
    switch_id_t  s2_src;
    logic        s2_miss;
    ip_addr_t    s2_host_ip;
    path_entry_t sel_path;

    // ====================
    // Stage 1 host read
    // ====================
    assign req_take   = req_valid && system_ready;
    assign host_raddr = req_dst_host;

    // Unknown host or source switch outside the loaded range
    assign req_miss = ({1'b0, req_dst_host} >= cfg_host_count)
                   || (req_src_sw == '0)
                   || (req_src_sw > cfg_max_sw_id);

    // ====================
    // Stage 2 bank read
    // ====================
    assign path_raddr = host_rdata.sw_id;   // Same address to every bank

    // Stage 3 picks the source switch's bank
    assign sel_path = path_rdata[s2_src];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_vld          <= 1'b0;
            s2_vld          <= 1'b0;
            resp_valid      <= 1'b0;
            resp_path_valid <= 1'b0;
        end else begin
            s1_vld          <= req_take;
            s2_vld          <= s1_vld;
            resp_valid      <= s2_vld;
            resp_path_valid <= s2_vld && sel_path.valid && !s2_miss;
        end
    end

    // Payload follows the valids
    always_ff @(posedge clk) begin
        s1_src           <= req_src_sw;
        s1_miss          <= req_miss;
        s2_src           <= s1_src;
        s2_miss          <= s1_miss;
        s2_host_ip       <= host_rdata.ip;
        resp_host_ip     <= s2_host_ip;
        resp_out_port    <= sel_path.out_port;
        resp_next_hop_ip <= sel_path.next_hop_ip;
    end

    // Fixed latency in both directions
    a_resp_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
        req_take |-> ##(`ROUTE_LOOKUP_LATENCY) resp_valid
    ) else $error("accepted request without response");

    a_resp_has_req: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |-> $past(req_take, `ROUTE_LOOKUP_LATENCY)
    ) else $error("response without accepted request");

endmodule

//--- hw/routing_lookup_top.sv
`timescale 1ns/1ns
`include "routing_consts.svh"

module routing_lookup_top (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [`ROUTE_MEM_AW-1:0]   mem_addr,
    input  logic [`ROUTE_MEM_DW-1:0]   mem_data,
    input  logic                       start_init,
    output logic                       init_busy,
    output logic                       system_ready,
    input  logic                       req_valid,
    input  routing_pkg::switch_id_t    req_src_sw,
    input  routing_pkg::host_idx_t     req_dst_host,
    output logic                       resp_valid,
    output logic                       resp_path_valid,
    output routing_pkg::ip_addr_t      resp_host_ip,
    output routing_pkg::port_t         resp_out_port,
    output routing_pkg::ip_addr_t      resp_next_hop_ip
);

    import routing_pkg::*;

    // Loader to tables
    logic                              host_we;
    host_idx_t                         host_waddr;
    host_entry_t                       host_wdata;
    logic [`ROUTE_MAX_SWITCHES-1:0]    path_we;
    switch_id_t                        path_waddr;
    path_entry_t                       path_wdata;

    // Tables to pipeline
    host_idx_t                         host_raddr;
    host_entry_t                       host_rdata;
    switch_id_t                        path_raddr;
    path_entry_t                       path_rdata [`ROUTE_MAX_SWITCHES];

    logic [$clog2(`ROUTE_MAX_HOSTS):0] cfg_host_count;
    switch_id_t                        cfg_max_sw_id;

    table_loader u_loader (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_init     (start_init),
        .mem_data       (mem_data),
        .mem_addr       (mem_addr),
        .init_busy      (init_busy),
        .system_ready   (system_ready),
        .host_we        (host_we),
        .host_waddr     (host_waddr),
        .host_wdata     (host_wdata),
        .path_we        (path_we),
        .path_waddr     (path_waddr),
        .path_wdata     (path_wdata),
        .cfg_host_count (cfg_host_count),
        .cfg_max_sw_id  (cfg_max_sw_id)
    );

    table_ram #(
        .entry_t (host_entry_t),
        .DEPTH   (`ROUTE_MAX_HOSTS)
    ) u_host_table (
        .clk        (clk),
        .write_en   (host_we),
        .write_addr (host_waddr),
        .write_data (host_wdata),
        .read_addr  (host_raddr),
        .read_data  (host_rdata)
    );

    // One bank per source switch, indexed by destination switch
    for (genvar g = 0; g < `ROUTE_MAX_SWITCHES; g++) begin : g_path_bank
        table_ram #(
            .entry_t (path_entry_t),
            .DEPTH   (`ROUTE_MAX_SWITCHES)
        ) u_bank (
            .clk        (clk),
            .write_en   (path_we[g]),
            .write_addr (path_waddr),
            .write_data (path_wdata),
            .read_addr  (path_raddr),
            .read_data  (path_rdata[g])
        );
    end

    lookup_pipeline u_pipeline (
        .clk              (clk),
        .rst_n            (rst_n),
        .system_ready     (system_ready),
        .cfg_host_count   (cfg_host_count),
        .cfg_max_sw_id    (cfg_max_sw_id),
        .req_valid        (req_valid),
        .req_src_sw       (req_src_sw),
        .req_dst_host     (req_dst_host),
        .host_rdata       (host_rdata),
        .path_rdata       (path_rdata),
        .host_raddr       (host_raddr),
        .path_raddr       (path_raddr),
        .resp_valid       (resp_valid),
        .resp_path_valid  (resp_path_valid),
        .resp_host_ip     (resp_host_ip),
        .resp_out_port    (resp_out_port),
        .resp_next_hop_ip (resp_next_hop_ip)
    );

endmodule

//--- hw/routing_pkg.sv
`include "routing_consts.svh"

package routing_pkg;

    // Basic fields
    typedef logic [$clog2(`ROUTE_MAX_HOSTS)-1:0]    host_idx_t;
    typedef logic [$clog2(`ROUTE_MAX_SWITCHES)-1:0] switch_id_t;
    typedef logic [31:0]                            ip_addr_t;
    typedef logic [15:0]                            port_t;

    // Host table entry, 36 bits
    typedef struct packed {
        ip_addr_t   ip;
        switch_id_t sw_id;     // Switch the host hangs off
    } host_entry_t;

    // Path bank entry, 49 bits
    typedef struct packed {
        logic       valid;
        port_t      out_port;
        ip_addr_t   next_hop_ip;
    } path_entry_t;

    // Loader FSM, one state per image region
    typedef enum logic [2:0] {
        st_idle,
        st_header,
        st_hosts,
        st_paths,
        st_done
    } loader_state_t;

endpackage

//--- hw/table_loader.sv
`timescale 1ns/1ns
`include "routing_consts.svh"

module table_loader (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              start_init,
    input  logic [`ROUTE_MEM_DW-1:0]          mem_data,
    output logic [`ROUTE_MEM_AW-1:0]          mem_addr,
    output logic                              init_busy,
    output logic                              system_ready,
    output logic                              host_we,
    output routing_pkg::host_idx_t            host_waddr,
    output routing_pkg::host_entry_t          host_wdata,
    output logic [`ROUTE_MAX_SWITCHES-1:0]    path_we,
    output routing_pkg::switch_id_t           path_waddr,
    output routing_pkg::path_entry_t          path_wdata,
    output logic [$clog2(`ROUTE_MAX_HOSTS):0] cfg_host_count,
    output routing_pkg::switch_id_t           cfg_max_sw_id
);

    import routing_pkg::*;

    loader_state_t state_q;
    logic          rd_vld_q;      // mem_data holds a requested word
    logic [1:0]    word_q;        // Word position inside current entry
    logic          last_word;
    host_idx_t     host_idx_q;
    switch_id_t    src_q;
    switch_id_t    dst_q;
    ip_addr_t      host_ip_q;
    logic          path_vld_q;
    port_t         path_port_q;

    assign init_busy    = state_q inside {st_header, st_hosts, st_paths};
    assign system_ready = (state_q == st_done);

    // Entry length depends on the region being read
    always_comb begin
        case (state_q)
            st_header: last_word = (word_q == 2'(`ROUTE_HDR_WORDS - 1));
            st_hosts:  last_word = (word_q == 2'(`ROUTE_HOST_WORDS - 1));
            st_paths:  last_word = (word_q == 2'(`ROUTE_PATH_WORDS - 1));
            default:   last_word = 1'b0;
        endcase
    end

    // ====================
    // Address stream and FSM
    // ====================
    // One address per cycle while busy. The word for each address comes back a
    // cycle later and the image regions are contiguous, so the FSM only follows
    // the returning words.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q        <= st_idle;
            mem_addr       <= '0;
            rd_vld_q       <= 1'b0;
            word_q         <= '0;
            host_idx_q     <= '0;
            src_q          <= '0;
            dst_q          <= '0;
            cfg_host_count <= '0;
            cfg_max_sw_id  <= '0;
            host_we        <= 1'b0;
            path_we        <= '0;
        end else begin
            host_we  <= 1'b0;     // Write strobes are single cycle
            path_we  <= '0;
            rd_vld_q <= init_busy;
            if (init_busy) begin
                mem_addr <= mem_addr + 1'b1;
            end
            if (init_busy && rd_vld_q) begin
                word_q <= last_word ? 2'd0 : word_q + 2'd1;
            end

            case (state_q)
                st_idle: begin
                    if (start_init) begin
                        state_q  <= st_header;
                        mem_addr <= '0;
                        word_q   <= '0;
                    end
                end

                st_header: begin
                    if (rd_vld_q && word_q == 2'd0) begin
                        cfg_host_count <= mem_data[$clog2(`ROUTE_MAX_HOSTS):0];
                    end
                    if (rd_vld_q && last_word) begin
                        cfg_max_sw_id <= mem_data[$bits(switch_id_t)-1:0];
                        host_idx_q    <= '0;
                        src_q         <= switch_id_t'(1);
                        dst_q         <= switch_id_t'(1);
                        // Empty host list skips straight to the paths
                        state_q <= (cfg_host_count == '0) ? st_paths : st_hosts;
                    end
                end

                st_hosts: begin
                    if (rd_vld_q && last_word) begin
                        host_we    <= 1'b1;
                        host_idx_q <= host_idx_q + 1'b1;
                        if ({1'b0, host_idx_q} == cfg_host_count - 1'b1) begin
                            state_q <= st_paths;
                        end
                    end
                end

                st_paths: begin
                    if (rd_vld_q && last_word) begin
                        path_we[src_q] <= 1'b1;
                        if (dst_q == cfg_max_sw_id) begin
                            dst_q <= switch_id_t'(1);   // Row-major, next source
                            if (src_q == cfg_max_sw_id) begin
                                state_q <= st_done;
                            end else begin
                                src_q <= src_q + 1'b1;
                            end
                        end else begin
                            dst_q <= dst_q + 1'b1;
                        end
                    end
                end

                st_done: ;   // Ready until reset

                default: state_q <= st_idle;
            endcase
        end
    end

    // ====================
    // Entry assembly
    // ====================
    always_ff @(posedge clk) begin
        if (rd_vld_q && state_q == st_hosts) begin
            if (!last_word) begin
                host_ip_q <= mem_data;
            end else begin
                host_waddr <= host_idx_q;
                host_wdata <= '{ip: host_ip_q, sw_id: mem_data[$bits(switch_id_t)-1:0]};
            end
        end
        if (rd_vld_q && state_q == st_paths) begin
            if (!last_word) begin
                path_vld_q  <= mem_data[`ROUTE_PATH_VALID_BIT];
                path_port_q <= mem_data[$bits(port_t)-1:0];
            end else begin
                path_waddr <= dst_q;
                path_wdata <= '{valid: path_vld_q, out_port: path_port_q,
                                next_hop_ip: mem_data};
            end
        end
    end

    // Header ranges, image is trusted otherwise
    a_host_count: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld_q && state_q == st_header && word_q == 2'd0)
            |-> (mem_data <= `ROUTE_MAX_HOSTS)
    ) else $error("host count 0x%0h exceeds table", mem_data);

    a_max_sw_id: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld_q && state_q == st_header && last_word)
            |-> (mem_data >= 1 && mem_data <= `ROUTE_MAX_SWITCHES - 1)
    ) else $error("highest switch id 0x%0h out of range", mem_data);

    a_busy_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(init_busy && system_ready)
    ) else $error("init_busy and system_ready both high");

endmodule

//--- hw/table_ram.sv
`timescale 1ns/1ns

module table_ram #(
    parameter type entry_t = logic [31:0],
    parameter int  DEPTH   = 16
) (
    input  logic                     clk,
    input  logic                     write_en,
    input  logic [$clog2(DEPTH)-1:0] write_addr,
    input  entry_t                   write_data,
    input  logic [$clog2(DEPTH)-1:0] read_addr,
    output entry_t                   read_data
);

    entry_t mem [DEPTH];

    // Synchronous write, registered read
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[write_addr] <= write_data;
        end
        read_data <= mem[read_addr];   // Old data on same-address write
    end

    // Loader must stay inside the table
    a_write_in_range: assert property (
        @(posedge clk) write_en |-> (int'(write_addr) < DEPTH)
    ) else $error("table_ram write_addr %0d out of range", write_addr);

endmodule

//--- include/routing_consts.svh
`ifndef ROUTING_CONSTS_SVH
`define ROUTING_CONSTS_SVH

// ====================
// Table sizes
// ====================
`define ROUTE_MAX_HOSTS       64   // Host table depth
`define ROUTE_MAX_SWITCHES    16   // Path banks, also depth of each bank

// ====================
// External memory
// ====================
`define ROUTE_MEM_AW          32
`define ROUTE_MEM_DW          32

// Image layout in words
`define ROUTE_HDR_WORDS       2    // Host count then highest switch id
`define ROUTE_HOST_WORDS      2    // IP then switch id
`define ROUTE_PATH_WORDS      2    // Flag and port then next hop IP
`define ROUTE_PATH_VALID_BIT  31

// ====================
// Lookup timing
// ====================
`define ROUTE_LOOKUP_LATENCY  3    // Request to response cycles

`endif

//--- routing_lookup_top.f
+incdir+include
hw/routing_pkg.sv
hw/table_ram.sv
hw/table_loader.sv
hw/lookup_pipeline.sv
hw/routing_lookup_top.sv
verification/route_mem_model.sv
verification/tb_routing_lookup.sv

//--- verification/route_mem_model.sv
`timescale 1ns/1ns
`include "routing_consts.svh"

module route_mem_model #(
    parameter int HOSTS  = 20,
    parameter int MAX_SW = 5,
    parameter int DEPTH  = 128
) (
    input  logic                     clk,
    input  logic [`ROUTE_MEM_AW-1:0] mem_addr,
    output logic [`ROUTE_MEM_DW-1:0] mem_data
);

    logic [31:0] image [DEPTH];
    logic [31:0] lfsr_state;

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // Pattern for words outside the image
    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return a ^ 32'hA5A5_0000;
    endfunction

    initial begin
        int          w;
        logic [31:0] flag;
        logic [31:0] out_port;
        lfsr_state = 32'd39;
        for (int a = 0; a < DEPTH; a++) image[a] = fill_word(32'(a));
        image[0] = 32'(HOSTS);
        image[1] = 32'(MAX_SW);
        w = 2;
        for (int k = 0; k < HOSTS; k++) begin
            image[w]     = rand_bits(32);                 // Host IP
            image[w + 1] = 32'(1 + (rand_bits(3) % MAX_SW));  // Switch 1..MAX_SW
            w = w + 2;
        end
        for (int p = 0; p < MAX_SW * MAX_SW; p++) begin
            flag         = rand_bits(1);                  // Valid flag
            out_port     = rand_bits(16);
            image[w]     = {flag[0], 15'd0, out_port[15:0]};
            image[w + 1] = rand_bits(32);                 // Next hop
            w = w + 2;
        end
    end

    // One cycle read latency
    always @(posedge clk) begin
        mem_data <= (mem_addr < 32'(DEPTH)) ? image[mem_addr[6:0]] : fill_word(mem_addr);
    end

endmodule

//--- verification/tb_routing_lookup.sv
`timescale 1ns/1ns

module tb_routing_lookup;

    localparam int HOSTS  = 20;
    localparam int MAX_SW = 5;
    localparam int LIMIT  = 1000;   // Cycles per wait

    typedef struct packed {
        logic        vld;
        logic        ipchk;    // Host exists so its IP is defined
        logic        pv;
        logic [31:0] ip;
        logic [15:0] port;
        logic [31:0] nh;
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] mem_addr;
    logic [31:0] mem_data;
    logic        start_init;
    logic        init_busy;
    logic        system_ready;
    logic        req_valid;
    logic [3:0]  req_src_sw;
    logic [5:0]  req_dst_host;
    logic        resp_valid;
    logic        resp_path_valid;
    logic [31:0] resp_host_ip;
    logic [15:0] resp_out_port;
    logic [31:0] resp_next_hop_ip;

    logic [31:0] img [128];
    logic [31:0] lfsr_state;
    exp_t        d_exp;
    exp_t        e1;
    exp_t        e2;
    exp_t        e3;
    int          errors;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;

    routing_lookup_top dut (.*);

    route_mem_model #(.HOSTS(HOSTS), .MAX_SW(MAX_SW)) mem_model (
        .clk(clk), .mem_addr(mem_addr), .mem_data(mem_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return v;
    endfunction

    // Two-level result straight from the image layout
    function automatic exp_t expect_resp(input logic [3:0] src, input logic [5:0] dst);
        exp_t e;
        int   hw;
        int   pw;
        int   sw;
        e = '0;
        e.vld = 1'b1;
        if (int'(dst) < HOSTS) begin
            hw      = 2 + 2 * int'(dst);
            e.ipchk = 1'b1;
            e.ip    = img[hw];
            sw      = int'(img[hw + 1][3:0]);
            if (src >= 4'd1 && int'(src) <= MAX_SW) begin
                pw     = 2 + 2 * HOSTS + 2 * ((int'(src) - 1) * MAX_SW + sw - 1);
                e.pv   = img[pw][31];
                e.port = img[pw][15:0];
                e.nh   = img[pw + 1];
            end
        end
        return e;
    endfunction

    // Expected responses delayed three cycles
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            e1 <= '0;
            e2 <= '0;
            e3 <= '0;
        end else begin
            e1     <= d_exp;
            e1.vld <= req_valid && system_ready;
            e2     <= e1;
            e3     <= e2;
        end
    end

    // ====================
    // Checks
    // ====================
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !init_busy && !system_ready && !resp_valid && mem_addr == '0)
        else begin
            $display("outputs not idle during reset");
            errors++;
        end
    a_busy_ready: assert property (@(posedge clk) disable iff (!rst_n)
        !(init_busy && system_ready))
        else begin
            $display("init_busy and system_ready high together");
            errors++;
        end
    a_stay_ready: assert property (@(posedge clk) disable iff (!rst_n)
        $past(system_ready) |-> system_ready && !init_busy)
        else begin
            $display("system_ready dropped or init_busy rose after ready");
            errors++;
        end
    a_resp_valid: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid == e3.vld)
        else begin
            $display("mismatch resp_valid exp %h got %h", $sampled(e3.vld), $sampled(resp_valid));
            errors++;
        end
    a_host_ip: assert property (@(posedge clk) disable iff (!rst_n)
        e3.vld && e3.ipchk |-> resp_host_ip == e3.ip)
        else begin
            $display("mismatch resp_host_ip exp %h got %h", $sampled(e3.ip),
                     $sampled(resp_host_ip));
            errors++;
        end
    a_path_valid: assert property (@(posedge clk) disable iff (!rst_n)
        e3.vld |-> resp_path_valid == e3.pv)
        else begin
            $display("mismatch resp_path_valid exp %h got %h", $sampled(e3.pv),
                     $sampled(resp_path_valid));
            errors++;
        end
    a_out_port: assert property (@(posedge clk) disable iff (!rst_n)
        e3.vld && e3.pv |-> resp_out_port == e3.port)
        else begin
            $display("mismatch resp_out_port exp %h got %h", $sampled(e3.port),
                     $sampled(resp_out_port));
            errors++;
        end
    a_next_hop: assert property (@(posedge clk) disable iff (!rst_n)
        e3.vld && e3.pv |-> resp_next_hop_ip == e3.nh)
        else begin
            $display("mismatch resp_next_hop_ip exp %h got %h", $sampled(e3.nh),
                     $sampled(resp_next_hop_ip));
            errors++;
        end

    // ====================
    // Stimulus helpers
    // ====================
    task automatic send_req(input logic [3:0] src, input logic [5:0] dst);
        @(negedge clk);
        req_valid    = 1'b1;
        req_src_sw   = src;
        req_dst_host = dst;
        d_exp        = expect_resp(src, dst);
    endtask

    task automatic send_random();
        logic [31:0] s;
        logic [31:0] h;
        s = rand_bits(3);    // Sources 0..7 hit both sides of the range
        h = rand_bits(5);
        send_req(s[3:0], h[5:0]);
    endtask

    task automatic go_idle();
        @(negedge clk);
        req_valid = 1'b0;
        d_exp     = '0;
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        while (!init_busy && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!init_busy) begin
            $display("timed out waiting for init_busy");
            errors++;
        end
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!system_ready && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (!system_ready) begin
            $display("timed out waiting for system_ready");
            errors++;
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((e1.vld || e2.vld || e3.vld) && n < LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (e1.vld || e2.vld || e3.vld) begin
            $display("timed out waiting for responses to drain");
            errors++;
        end
        @(posedge clk);
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            pass_cnt++;
            $display("test %s: ok", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed", name);
        end
        err_mark = errors;
    endtask

    initial begin
        rst_n        = 1'b0;
        start_init   = 1'b0;
        req_valid    = 1'b0;
        req_src_sw   = '0;
        req_dst_host = '0;
        d_exp        = '0;
        lfsr_state   = 32'd39;
        errors       = 0;
        err_mark     = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (img[i]) img[i] = mem_model.image[i];

        @(negedge clk);
        start_init = 1'b1;
        @(negedge clk);
        start_init = 1'b0;
        wait_busy();
        end_test("init_start");

        for (int i = 0; i < 10; i++) send_random();   // Ignored while loading
        go_idle();
        end_test("early_requests");

        wait_ready();
        wait_drain();
        end_test("init_done");

        for (int s = 1; s <= MAX_SW; s++) begin
            send_req(4'(s), 6'd0);
            send_req(4'(s), 6'(s * 3));
            send_req(4'(s), 6'(HOSTS - 1));
        end
        go_idle();
        wait_drain();
        end_test("directed_lookups");

        send_req(4'd3, 6'd20);
        send_req(4'd3, 6'd63);
        send_req(4'd0, 6'd4);
        send_req(4'd6, 6'd4);
        send_req(4'd15, 6'd0);
        go_idle();
        wait_drain();
        end_test("out_of_range");

        for (int i = 0; i < 200; i++) send_random();
        go_idle();
        wait_drain();
        end_test("random_stream");

        @(negedge clk);
        start_init = 1'b1;
        @(negedge clk);
        start_init = 1'b0;
        repeat (10) @(posedge clk);
        send_req(4'd2, 6'd5);
        go_idle();
        wait_drain();
        end_test("restart_ignored");

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (errors == 0 && fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
